//--- hdl/robPkg.sv
//############################
// ROB_DEPTH must stay a power of two so that tags wrap by themselves.
// All widths are derived from the counts below.
//############################
`default_nettype none

package robPkg;

	localparam int REG_COUNT = 32; // architectural registers x0 to x31.
	localparam int ROB_DEPTH = 8; // reorder-buffer entries in flight.
	localparam int DATA_W = 32; // width of one result value.

	localparam int REG_W = $clog2(REG_COUNT); // bits of a register index.
	localparam int TAG_W = $clog2(ROB_DEPTH); // bits of a reorder-buffer tag.

	typedef logic [REG_W-1:0] regIdxT; // architectural register index.
	typedef logic [TAG_W-1:0] robTagT; // reorder-buffer slot, wraps at ROB_DEPTH.
	typedef logic [TAG_W:0] robCntT; // occupancy needs one more bit to reach ROB_DEPTH.
	typedef logic [DATA_W-1:0] dataT; // result value carried by writeback and commit.

	// the controller only ever sits in one of these two states.
	typedef enum logic {
		sRun, // dispatch, writeback and commit proceed.
		sFlush // one cycle in which all in-flight work is dropped.
	} dispStateT;

endpackage

`default_nettype wire

//--- hdl/regStatus.sv
//############################
// Written on the rising edge, so lookups see the table before this dispatch.
// x0 is never marked busy and never looked up as pending.
//############################
`default_nettype none

module regStatus (
	input wire logic clk,
	input wire logic arstN,
	input wire robPkg::regIdxT rs1,
	input wire robPkg::regIdxT rs2,
	input wire logic writeEn,
	input wire robPkg::regIdxT destReg,
	input wire robPkg::robTagT destTag,
	input wire logic commitEn,
	input wire robPkg::regIdxT commitReg,
	input wire robPkg::robTagT commitTag,
	input wire logic clearAll,
	output logic busy1,
	output logic busy2,
	output robPkg::robTagT tag1,
	output robPkg::robTagT tag2
);

	import robPkg::*;

	logic [REG_COUNT-1:0] busy; // set while an uncommitted instruction will write the register.
	robTagT producer [REG_COUNT]; // tag of the newest instruction writing each register.

	logic mapWrite; // a dispatch that really renames a register.
	logic mapFree; // a commit by the entry the table still names.

	assign mapWrite = writeEn && (destReg != '0); // x0 writes are dropped here.
	assign mapFree = commitEn && (commitReg != '0) && (producer[commitReg] == commitTag);

	// both source ports read the same table through independent muxes.
	assign busy1 = busy[rs1];
	assign busy2 = busy[rs2];
	assign tag1 = producer[rs1]; // only meaningful while busy1 is high.
	assign tag2 = producer[rs2]; // only meaningful while busy2 is high.

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			busy <= '0; // nothing is in flight after reset.
		end else if (clearAll) begin
			busy <= '0; // a flush forgets every pending producer.
		end else begin
			if (mapFree) begin
				busy[commitReg] <= 1'b0; // an older writer committing leaves a newer mapping alone.
			end
			if (mapWrite) begin
				busy[destReg] <= 1'b1; // placed last so a new mapping beats a same-cycle commit.
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mapWrite) begin
			producer[destReg] <= destTag; // the newest dispatch becomes the producer.
		end
	end

	// clearAll and writeEn come from different states of the controller.
	assert property (@(posedge clk) disable iff (!arstN) !(clearAll && writeEn))
		else $error("regStatus: flush clear and rename requested in the same cycle.");

	// a commit that frees a register must have marked it busy at some earlier dispatch.
	assert property (@(posedge clk) disable iff (!arstN) mapFree |-> busy[commitReg])
		else $error("regStatus: commit frees a register that is not busy.");

endmodule

`default_nettype wire

//--- hdl/robPointers.sv
//############################
// Tags wrap modulo ROB_DEPTH. The decoder's credits keep the tail off a full buffer.
//############################
`default_nettype none

module robPointers (
	input wire logic clk,
	input wire logic arstN,
	input wire logic advanceTail,
	input wire logic advanceHead,
	input wire logic clearAll,
	output robPkg::robTagT tailTag,
	output robPkg::robTagT headTag,
	output robPkg::robCntT count,
	output logic empty,
	output logic full
);

	import robPkg::*;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			tailTag <= '0;
			headTag <= '0;
			count <= '0;
		end else if (clearAll) begin
			tailTag <= '0; // a flush restarts allocation at entry 0.
			headTag <= '0;
			count <= '0;
		end else begin
			if (advanceTail) begin
				tailTag <= tailTag + robTagT'(1); // wraps on its own since ROB_DEPTH is 2**TAG_W.
			end
			if (advanceHead) begin
				headTag <= headTag + robTagT'(1); // oldest entry has committed.
			end
			case ({advanceTail, advanceHead})
				2'b10: count <= count + robCntT'(1); // dispatch only.
				2'b01: count <= count - robCntT'(1); // commit only.
				default: count <= count; // both or neither leave occupancy as is.
			endcase
		end
	end

	assign empty = (count == '0);
	assign full = (count == robCntT'(ROB_DEPTH)); // head and tail meet with every entry in use.

	// a dispatch on a full buffer means the decoder spent a credit it did not have.
	assert property (@(posedge clk) disable iff (!arstN) advanceTail |-> !full)
		else $error("robPointers: dispatch while the reorder buffer is full.");

	// commit is gated on a done head, which needs a dispatched entry.
	assert property (@(posedge clk) disable iff (!arstN) advanceHead |-> !empty)
		else $error("robPointers: commit while the reorder buffer is empty.");

endmodule

`default_nettype wire

//--- hdl/dispatchControl.sv
//############################
// Flush is sampled at the edge and always costs exactly one sFlush cycle.
//############################
`default_nettype none

module dispatchControl (
	input wire logic clk,
	input wire logic arstN,
	input wire logic flush,
	input wire logic dispValid,
	input wire logic headDone,
	input wire logic empty,
	output logic dispEnable,
	output logic commitEnable,
	output logic flushClear,
	output logic flushDone
);

	import robPkg::*;

	dispStateT state; // current controller state.
	dispStateT stateNext; // state taken at the next edge.

	always_comb begin
		stateNext = state;
		case (state)
			sRun: begin
				if (flush) begin
					stateNext = sFlush; // in-flight work is dropped next cycle.
				end
			end
			sFlush: stateNext = sRun; // the clear takes a single edge.
			default: stateNext = sRun;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			state <= sRun; // ready to accept dispatch straight out of reset.
		end else begin
			state <= stateNext;
		end
	end

	assign dispEnable = (state == sRun) && dispValid; // the decoder only asks while it holds a credit.
	assign commitEnable = (state == sRun) && !empty && headDone; // the oldest entry has its result.
	assign flushClear = (state == sFlush); // wipes tables, done flags and pointers at the next edge.
	assign flushDone = (state == sFlush); // tells the decoder to refill its credits.

	// the decoder loses its credits with flushDone and may not dispatch in that cycle.
	assert property (@(posedge clk) disable iff (!arstN) (state == sFlush) |-> !dispValid)
		else $error("dispatchControl: dispatch offered during the flush cycle.");

endmodule

`default_nettype wire

//--- hdl/robEntries.sv
//############################
// Results land at the edge and read as ready from the next cycle, with no bypass.
// Writeback is ignored in the flush cycle.
//############################
`default_nettype none

module robEntries (
	input wire logic clk,
	input wire logic arstN,
	input wire logic allocEn,
	input wire robPkg::robTagT allocTag,
	input wire robPkg::regIdxT allocRd,
	input wire logic allocWe,
	input wire logic wbValid,
	input wire robPkg::robTagT wbTag,
	input wire robPkg::dataT wbValue,
	input wire robPkg::robTagT rdTag1,
	input wire robPkg::robTagT rdTag2,
	input wire robPkg::robTagT headTag,
	input wire logic clearAll,
	output logic ready1,
	output logic ready2,
	output robPkg::dataT value1,
	output robPkg::dataT value2,
	output logic headDone,
	output robPkg::regIdxT headRd,
	output logic headWe,
	output robPkg::dataT headValue
);

	import robPkg::*;

	logic [ROB_DEPTH-1:0] done; // result has been written back.
	logic [ROB_DEPTH-1:0] live; // entry has been handed out since the last clear.
	logic [ROB_DEPTH-1:0] destWe; // instruction writes an architectural register.
	regIdxT destRd [ROB_DEPTH]; // destination register of each entry.
	dataT result [ROB_DEPTH]; // value delivered by the execution unit.

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			done <= '0;
			live <= '0;
		end else if (clearAll) begin
			done <= '0; // this also swallows any writeback in the flush cycle.
			live <= '0;
		end else begin
			if (wbValid) begin
				done[wbTag] <= 1'b1; // out-of-order completion by tag.
			end
			if (allocEn) begin
				done[allocTag] <= 1'b0; // a reused slot waits for its new result.
				live[allocTag] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (allocEn) begin
			destRd[allocTag] <= allocRd;
			destWe[allocTag] <= allocWe;
		end
		if (wbValid) begin
			result[wbTag] <= wbValue; // harmless during a flush since done stays clear.
		end
	end

	// forwarding ports follow the producer tags from the status table.
	assign ready1 = done[rdTag1];
	assign ready2 = done[rdTag2];
	assign value1 = result[rdTag1];
	assign value2 = result[rdTag2];

	// the head entry feeds commit.
	assign headDone = done[headTag];
	assign headRd = destRd[headTag];
	assign headWe = destWe[headTag];
	assign headValue = result[headTag];

	// only a dispatched entry that has not yet completed may be written back.
	assert property (@(posedge clk) disable iff (!arstN)
			(wbValid && !clearAll) |-> (live[wbTag] && !done[wbTag]))
		else $error("robEntries: writeback to tag %0d, which is not awaiting a result.", wbTag);

endmodule

`default_nettype wire

//--- hdl/renameTop.sv
//############################
// src*Ready and src*Value mean something only while src*Busy is high.
// The commit port has no ready, so the receiver must always accept.
//############################
`default_nettype none

module renameTop (
	input wire logic clk,
	input wire logic arstN,
	input wire logic dispValid,
	input wire robPkg::regIdxT dispRs1,
	input wire robPkg::regIdxT dispRs2,
	input wire robPkg::regIdxT dispRd,
	input wire logic dispWe,
	output logic src1Busy,
	output robPkg::robTagT src1Tag,
	output logic src1Ready,
	output robPkg::dataT src1Value,
	output logic src2Busy,
	output robPkg::robTagT src2Tag,
	output logic src2Ready,
	output robPkg::dataT src2Value,
	output robPkg::robTagT dispTag,
	output logic creditReturn,
	output logic flushDone,
	input wire logic wbValid,
	input wire robPkg::robTagT wbTag,
	input wire robPkg::dataT wbValue,
	output logic commitValid,
	output robPkg::regIdxT commitRd,
	output logic commitWe,
	output robPkg::dataT commitValue,
	input wire logic flush
);

	import robPkg::*;

	logic dispEnable; // dispatch accepted this cycle.
	logic commitEnable; // head entry retires this cycle.
	logic flushClear; // wipe all in-flight state at the next edge.
	logic robEmpty;
	logic headDone;
	robTagT tailTag; // slot the next dispatch takes.
	robTagT headTag; // oldest uncommitted slot.

	assign dispTag = tailTag;
	assign commitValid = commitEnable;
	assign creditReturn = commitEnable; // one credit back per retired instruction.

	regStatus uStatus (
		.clk(clk), .arstN(arstN),
		.rs1(dispRs1), .rs2(dispRs2),
		.writeEn(dispEnable && dispWe), .destReg(dispRd), .destTag(tailTag),
		.commitEn(commitEnable && commitWe), .commitReg(commitRd), .commitTag(headTag),
		.clearAll(flushClear),
		.busy1(src1Busy), .busy2(src2Busy), .tag1(src1Tag), .tag2(src2Tag)
	);

	robPointers uPointers (
		.clk(clk), .arstN(arstN),
		.advanceTail(dispEnable), .advanceHead(commitEnable), .clearAll(flushClear),
		.tailTag(tailTag), .headTag(headTag), .count(), .empty(robEmpty), .full()
	);

	dispatchControl uControl (
		.clk(clk), .arstN(arstN),
		.flush(flush), .dispValid(dispValid), .headDone(headDone), .empty(robEmpty),
		.dispEnable(dispEnable), .commitEnable(commitEnable),
		.flushClear(flushClear), .flushDone(flushDone)
	);

	robEntries uEntries (
		.clk(clk), .arstN(arstN),
		.allocEn(dispEnable), .allocTag(tailTag), .allocRd(dispRd), .allocWe(dispWe),
		.wbValid(wbValid), .wbTag(wbTag), .wbValue(wbValue),
		.rdTag1(src1Tag), .rdTag2(src2Tag), .headTag(headTag),
		.clearAll(flushClear),
		.ready1(src1Ready), .ready2(src2Ready), .value1(src1Value), .value2(src2Value),
		.headDone(headDone), .headRd(commitRd), .headWe(commitWe), .headValue(commitValue)
	);

endmodule

`default_nettype wire

//--- tests/renameTb.sv
//############################
// Rows run one per cycle after an 8-cycle reset; the row order sets the ROB tags.
// Writeback rows must name an entry that is in flight and not yet done.
//############################
`default_nettype none

module renameTb;
	timeunit 1ns;
	timeprecision 100ps;

	import robPkg::*;

	typedef enum logic [1:0] {aIdle, aDisp, aWb, aFlush} actT; // what the row does this cycle.

	logic clk;
	logic arstN;
	logic dispValid;
	regIdxT dispRs1;
	regIdxT dispRs2;
	regIdxT dispRd;
	logic dispWe;
	logic src1Busy;
	robTagT src1Tag;
	logic src1Ready;
	dataT src1Value;
	logic src2Busy;
	robTagT src2Tag;
	logic src2Ready;
	dataT src2Value;
	robTagT dispTag;
	logic creditReturn;
	logic flushDone;
	logic wbValid;
	robTagT wbTag;
	dataT wbValue;
	logic commitValid;
	regIdxT commitRd;
	logic commitWe;
	dataT commitValue;
	logic flush;

	string rowName [$]; // the stimulus table holds one entry per cycle.
	actT rowAct [$];
	regIdxT rowRs1 [$];
	regIdxT rowRs2 [$];
	regIdxT rowRd [$];
	logic rowWe [$];
	robTagT rowWbTag [$];
	logic rowBusy1 [$]; // expected src1Busy.
	logic rowBusy2 [$]; // expected src2Busy.

	logic [REG_COUNT-1:0] refBusy; // reference rename map.
	robTagT refTag [REG_COUNT];
	logic [ROB_DEPTH-1:0] entDone; // reference ROB entries are indexed by tag.
	dataT entValue [ROB_DEPTH];
	regIdxT entRd [ROB_DEPTH];
	logic entWe [ROB_DEPTH];
	robTagT order [$]; // in-flight tags, oldest first.
	robTagT refTail;
	logic refFlushing; // the model sits in the one flush cycle.
	logic commitDue; // model expects a commit in this cycle.

	int seed;
	int credits; // decoder credits that creditReturn and flushDone give back.
	int errors;
	int rowErrors;
	int cleanRows;
	int cycles = 0;
	int cycleLimit = 1000;
	string curName;
	dataT wbDrawn; // value sent with the current writeback row.

	renameTop i_dut (
		.clk(clk), .arstN(arstN),
		.dispValid(dispValid), .dispRs1(dispRs1), .dispRs2(dispRs2), .dispRd(dispRd),
		.dispWe(dispWe),
		.src1Busy(src1Busy), .src1Tag(src1Tag), .src1Ready(src1Ready), .src1Value(src1Value),
		.src2Busy(src2Busy), .src2Tag(src2Tag), .src2Ready(src2Ready), .src2Value(src2Value),
		.dispTag(dispTag), .creditReturn(creditReturn), .flushDone(flushDone),
		.wbValid(wbValid), .wbTag(wbTag), .wbValue(wbValue),
		.commitValid(commitValid), .commitRd(commitRd), .commitWe(commitWe),
		.commitValue(commitValue), .flush(flush)
	);

	always #5 clk = ~clk; // 10 ns period.

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit) begin
			$display("timeout after %0d cycles, the row loop never finished.", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	task automatic addRow(input string name, input actT act, input int rs1, input int rs2,
			input int rd, input int we, input int tag, input int busy1, input int busy2);
		rowName.push_back(name);
		rowAct.push_back(act);
		rowRs1.push_back(regIdxT'(rs1));
		rowRs2.push_back(regIdxT'(rs2));
		rowRd.push_back(regIdxT'(rd));
		rowWe.push_back(we != 0);
		rowWbTag.push_back(robTagT'(tag));
		rowBusy1.push_back(busy1 != 0);
		rowBusy2.push_back(busy2 != 0);
	endtask

	task automatic buildTable();
		addRow("idle-start", aIdle, 1, 2, 0, 0, 0, 0, 0); // nothing renamed yet.
		addRow("disp-x1", aDisp, 1, 2, 1, 1, 0, 0, 0);
		addRow("disp-x2-reads-x1", aDisp, 1, 3, 2, 1, 0, 1, 0);
		addRow("disp-x1-self", aDisp, 1, 2, 1, 1, 0, 1, 1); // sees the older x1 producer.
		addRow("disp-x0", aDisp, 0, 1, 0, 1, 0, 0, 1);
		addRow("lookup-x0", aIdle, 0, 2, 0, 0, 0, 0, 1); // x0 stays free.
		addRow("wb-tag2", aWb, 1, 2, 0, 0, 2, 1, 1); // writebacks arrive out of order.
		addRow("fwd-x1", aIdle, 1, 0, 0, 0, 0, 1, 0);
		addRow("wb-tag1", aWb, 2, 1, 0, 0, 1, 1, 1);
		addRow("fwd-x2", aIdle, 2, 1, 0, 0, 0, 1, 1);
		addRow("wb-tag0", aWb, 1, 2, 0, 0, 0, 1, 1);
		addRow("commit-tag0", aIdle, 1, 2, 0, 0, 0, 1, 1);
		addRow("stale-x1", aIdle, 1, 2, 0, 0, 0, 1, 1); // x1 still names tag 2.
		addRow("commit-tag2", aIdle, 1, 2, 0, 0, 0, 1, 0);
		addRow("wb-tag3", aWb, 1, 0, 0, 0, 3, 0, 0);
		addRow("commit-x0", aIdle, 0, 1, 0, 0, 0, 0, 0);
		addRow("disp-nowrite", aDisp, 6, 7, 7, 0, 0, 0, 0);
		addRow("disp-x5", aDisp, 5, 6, 5, 1, 0, 0, 0);
		addRow("disp-x6", aDisp, 5, 6, 6, 1, 0, 1, 0);
		addRow("wb-tag4", aWb, 7, 5, 0, 0, 4, 0, 1); // x7 was never renamed.
		addRow("commit-nowrite", aIdle, 7, 5, 0, 0, 0, 0, 1);
		addRow("wb-tag6", aWb, 7, 5, 0, 0, 6, 0, 1);
		addRow("flush-req", aFlush, 5, 6, 0, 0, 0, 1, 1);
		addRow("flush-cycle-wb", aWb, 5, 6, 0, 0, 5, 1, 1); // ignored by the DUT.
		addRow("after-flush", aIdle, 5, 6, 0, 0, 0, 0, 0);
		for (int k = 8; k <= 15; k++) begin
			addRow($sformatf("refill-x%0d", k), aDisp, k - 1, 5, k, 1, 0, (k > 8) ? 1 : 0, 0);
		end
		addRow("wb-tag0-full", aWb, 15, 8, 0, 0, 0, 1, 1);
		addRow("commit-full", aIdle, 8, 15, 0, 0, 0, 1, 1);
		addRow("x8-freed", aIdle, 8, 9, 0, 0, 0, 0, 1);
	endtask

	task automatic resetModel();
		refBusy = '0;
		entDone = '0;
		order.delete();
		refTail = '0;
		refFlushing = 1'b0;
	endtask

	task automatic reportMismatch(input string field, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("ERR %s %s expected %0h actual %0h", curName, field, expected, actual);
		rowErrors++;
	endtask

	task automatic checkSource(input string which, input regIdxT rs, input logic expBusy,
			input logic busy, input robTagT tag, input logic ready, input dataT value);
		robTagT t;
		t = refTag[rs];
		if (refBusy[rs] !== expBusy) begin
			$display("row %s expects x%0d busy %0d but the model says otherwise.", curName, rs,
				expBusy);
			rowErrors++;
		end
		if (busy !== expBusy) reportMismatch({which, "Busy"}, 32'(expBusy), 32'(busy));
		if (expBusy) begin
			if (tag !== t) reportMismatch({which, "Tag"}, 32'(t), 32'(tag));
			if (ready !== entDone[t]) begin
				reportMismatch({which, "Ready"}, 32'(entDone[t]), 32'(ready));
			end
			if (entDone[t] && (value !== entValue[t])) begin
				reportMismatch({which, "Value"}, entValue[t], value);
			end
		end
	endtask

	task automatic applyRow(input int r);
		dispValid <= (rowAct[r] == aDisp);
		dispRs1 <= rowRs1[r];
		dispRs2 <= rowRs2[r];
		dispRd <= rowRd[r];
		dispWe <= rowWe[r];
		wbValid <= (rowAct[r] == aWb);
		wbTag <= rowWbTag[r];
		flush <= (rowAct[r] == aFlush);
		if (rowAct[r] == aWb) begin
			wbDrawn = $random(seed);
			wbValue <= wbDrawn;
		end
	endtask

	task automatic checkRow(input int r);
		robTagT h;
		curName = rowName[r];
		rowErrors = 0;
		checkSource("src1", rowRs1[r], rowBusy1[r], src1Busy, src1Tag, src1Ready, src1Value);
		checkSource("src2", rowRs2[r], rowBusy2[r], src2Busy, src2Tag, src2Ready, src2Value);
		commitDue = !refFlushing && (order.size() > 0) && entDone[order[0]]; // head is done.
		if (commitValid !== commitDue) begin
			reportMismatch("commitValid", 32'(commitDue), 32'(commitValid));
		end
		if (creditReturn !== commitDue) begin
			reportMismatch("creditReturn", 32'(commitDue), 32'(creditReturn));
		end
		if (flushDone !== refFlushing) begin
			reportMismatch("flushDone", 32'(refFlushing), 32'(flushDone));
		end
		if (commitDue) begin
			h = order[0];
			if (commitRd !== entRd[h]) reportMismatch("commitRd", 32'(entRd[h]), 32'(commitRd));
			if (commitWe !== entWe[h]) reportMismatch("commitWe", 32'(entWe[h]), 32'(commitWe));
			if (commitValue !== entValue[h]) begin
				reportMismatch("commitValue", entValue[h], commitValue);
			end
		end
		if (rowAct[r] == aDisp) begin
			if (credits == 0) begin
				$display("row %s dispatches while the decoder holds no credit.", curName);
				rowErrors++;
			end
			credits--;
			if (dispTag !== refTail) reportMismatch("dispTag", 32'(refTail), 32'(dispTag));
		end
		if (creditReturn) credits++; // usable from the next cycle on.
		if (flushDone) credits = ROB_DEPTH;
	endtask

	task automatic stepModel(input int r);
		robTagT h;
		if (refFlushing) begin
			resetModel(); // the flush edge wipes everything, writeback included.
		end else begin
			if (commitDue) begin
				h = order.pop_front();
				if (entWe[h] && (entRd[h] != '0) && (refTag[entRd[h]] == h)) begin
					refBusy[entRd[h]] = 1'b0;
				end
			end
			if (rowAct[r] == aWb) begin
				entDone[rowWbTag[r]] = 1'b1;
				entValue[rowWbTag[r]] = wbDrawn;
			end
			if (rowAct[r] == aDisp) begin
				entRd[refTail] = rowRd[r];
				entWe[refTail] = rowWe[r];
				entDone[refTail] = 1'b0;
				order.push_back(refTail);
				if (rowWe[r] && (rowRd[r] != '0)) begin
					refBusy[rowRd[r]] = 1'b1; // the new mapping wins over a same-cycle commit.
					refTag[rowRd[r]] = refTail;
				end
				refTail++;
			end
			if (rowAct[r] == aFlush) refFlushing = 1'b1;
		end
	endtask

	initial begin
		clk = 1'b0;
		arstN = 1'b0;
		dispValid = 1'b0;
		dispRs1 = '0;
		dispRs2 = '0;
		dispRd = '0;
		dispWe = 1'b0;
		wbValid = 1'b0;
		wbTag = '0;
		wbValue = '0;
		flush = 1'b0;
		seed = 52788;
		errors = 0;
		cleanRows = 0;
		credits = ROB_DEPTH; // one credit per ROB entry out of reset.
		resetModel();
		buildTable();
		cycleLimit = 4 * rowName.size() + 100;
		repeat (8) @(posedge clk);
		arstN <= 1'b1;
		for (int r = 0; r < rowName.size(); r++) begin
			@(posedge clk);
			applyRow(r);
			@(negedge clk); // outputs are settled half a cycle after the drive.
			checkRow(r);
			stepModel(r);
			errors += rowErrors;
			if (rowErrors == 0) begin
				cleanRows++;
				$display("ok   %s", curName);
			end else begin
				$display("bad  %s with %0d mismatches", curName, rowErrors);
			end
		end
		$display("%0d of %0d rows clean, %0d mismatches", cleanRows, rowName.size(), errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- robRename.f
hdl/robPkg.sv
hdl/regStatus.sv
hdl/robPointers.sv
hdl/dispatchControl.sv
hdl/robEntries.sv
hdl/renameTop.sv
tests/renameTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module renameTb -f robRename.f -o renameSim &&
./obj_dir/renameSim | tee /dev/stderr | grep -q "All checks passed" &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation did not pass"; exit 1; }
